// ==== tb.f ====
verilog/exec_pkg.sv
verilog/pipe_reg.sv
verilog/alu_datapath.sv
verilog/exec_alu.sv
verif/exec_alu_chk.sv
verif/exec_alu_tb.sv

// ==== Makefile ====
# Verilator build and run of the ALU execute unit testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
	  -f tb.f --top-module exec_alu_tb

run: compile
	./obj_dir/Vexec_alu_tb +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || \
	  { echo "Run ended without a result line"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/exec_alu_tb.sv ====
//----------------------------------------------------------------------
// Testbench for the ALU execute unit. Sends directed corner cases and
// random micro-ops, models each result at the D transfer and checks
// every W transfer against the model queue in order.
//----------------------------------------------------------------------

`timescale 1ns/1ns

module exec_alu_tb import exec_pkg::*; ();

  // Cycle limits for each wait loop
  localparam int READY_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int RANDOM_COUNT  = 300;

  logic   clk;
  logic   rst;
  logic   d_val;
  logic   d_rdy;
  d_x_msg d_msg;
  logic   w_val;
  logic   w_rdy;
  x_w_msg w_msg;

  // Random w_rdy when set
  logic   bp_phase;

  // Expected writebacks in acceptance order
  x_w_msg expected_q [$];
  x_w_msg head;

  int mismatches = 0;
  int timeouts   = 0;
  int seq_cnt    = 0;
  logic [31:0] pc_cnt = 32'h0000_1000;

  // Operand corners including 0x20 to show only op2[4:0] shifts
  logic [31:0] corners [6] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
                               32'h0000_001f, 32'h7fff_ffff, 32'h0000_0020};

  exec_alu dut0 (.*);

  always #2 clk = ~clk;

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------

  function automatic x_w_msg expected_wb(input d_x_msg m);
    x_w_msg      e;
    logic [4:0]  s;
    logic [31:0] fill;
    s    = m.op2[4:0];
    // Sign fill for the upper bits of an arithmetic shift
    fill = m.op1[31] ? ~(32'hffff_ffff >> s) : 32'd0;
    e.pc      = m.pc;
    e.seq_num = m.seq_num;
    e.waddr   = m.waddr;
    e.wen     = (m.waddr != 5'd0);
    case (m.uop)
      UOP_ADD:  e.wdata = m.op1 + m.op2;
      UOP_SUB:  e.wdata = m.op1 - m.op2;
      UOP_AND:  e.wdata = m.op1 & m.op2;
      UOP_OR:   e.wdata = m.op1 | m.op2;
      UOP_XOR:  e.wdata = m.op1 ^ m.op2;
      UOP_SLT:  e.wdata = ($signed(m.op1) < $signed(m.op2)) ? 32'd1 : 32'd0;
      UOP_SLTU: e.wdata = (m.op1 < m.op2) ? 32'd1 : 32'd0;
      UOP_SLL:  e.wdata = m.op1 << s;
      UOP_SRL:  e.wdata = m.op1 >> s;
      UOP_SRA:  e.wdata = (m.op1 >> s) | fill;
      UOP_LUI:  e.wdata = m.op2;
      default:  e.wdata = 32'd0;
    endcase
    return e;
  endfunction

  //--------------------------------------------------------------------
  // Scoreboard
  //--------------------------------------------------------------------

  // Pop before push since a new D message never leaves on its accept edge
  always @(posedge clk) begin
    if (!rst) begin
      if (w_val && w_rdy) begin
        if (expected_q.size() == 0) begin
          $display("Writeback at %0t with no message outstanding", $time);
          mismatches++;
        end else begin
          head = expected_q.pop_front();
          assert (w_msg == head) else begin
            $display("FAIL %0t: got seq=%0d pc=%h waddr=%0d wdata=%h wen=%b", $time,
                     w_msg.seq_num, w_msg.pc, w_msg.waddr, w_msg.wdata, w_msg.wen);
            $display("  expected seq=%0d pc=%h waddr=%0d wdata=%h wen=%b",
                     head.seq_num, head.pc, head.waddr, head.wdata, head.wen);
            mismatches++;
          end
        end
      end
      if (d_val && d_rdy) begin
        expected_q.push_back(expected_wb(d_msg));
      end
    end
  end

  // Writeback ready held high or random
  always @(posedge clk) begin
    if (bp_phase) begin
      w_rdy <= ($urandom_range(2, 0) != 0);
    end else begin
      w_rdy <= 1'b1;
    end
  end

  //--------------------------------------------------------------------
  // Drivers
  //--------------------------------------------------------------------

  // Holds the message until the edge where d_rdy is seen high
  task automatic send_op(input rv_uop u, input logic [31:0] a, input logic [31:0] b,
                         input logic [4:0] rd);
    d_x_msg m;
    int     waited;
    m.pc      = pc_cnt;
    m.seq_num = SEQ_NUM_BITS'(seq_cnt);
    m.op1     = a;
    m.op2     = b;
    m.waddr   = rd;
    m.uop     = u;
    pc_cnt    = pc_cnt + 32'd4;
    seq_cnt++;
    d_val <= 1'b1;
    d_msg <= m;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!d_rdy && waited < READY_TIMEOUT);
    if (!d_rdy) begin
      $display("Timeout at %0t: d_rdy stayed low for %0d cycles", $time, waited);
      timeouts++;
    end
  endtask

  task automatic random_op_and_gap();
    logic [31:0] b;
    int          gap;
    b = $urandom;
    // Small op2 now and then for short shifts
    if ($urandom_range(3, 0) == 0) begin
      b = b & 32'h0000_003f;
    end
    send_op(rv_uop'(4'($urandom_range(10, 0))), $urandom, b, 5'($urandom));
    gap = $urandom_range(3, 0);
    if (gap != 0) begin
      d_val <= 1'b0;
      repeat (gap) @(posedge clk);
    end
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------

  initial begin
    int waited;
    void'($urandom(95931));
    clk      = 1'b0;
    rst      = 1'b1;
    d_val    = 1'b0;
    d_msg    = '0;
    w_rdy    = 1'b1;
    bp_phase = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // Directed pass over every uop and corner pair
    for (int u = 0; u < 11; u++) begin
      for (int i = 0; i < 6; i++) begin
        for (int j = 0; j < 6; j++) begin
          send_op(rv_uop'(u[3:0]), corners[i], corners[j], 5'(seq_cnt % 31 + 1));
        end
      end
    end
    // Write to x0
    send_op(UOP_ADD, 32'h1234_5678, 32'h0000_0001, 5'd0);

    // Random traffic with back-pressure in the second half
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      if (n == RANDOM_COUNT / 2) begin
        bp_phase <= 1'b1;
      end
      random_op_and_gap();
    end
    d_val    <= 1'b0;
    bp_phase <= 1'b0;

    // Drain the model queue
    waited = 0;
    while (expected_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    // Room for the last accepted message to reach W
    repeat (4) @(posedge clk);
    if (expected_q.size() != 0) begin
      $display("Timeout: %0d results never left the writeback port", expected_q.size());
      timeouts++;
    end

    $display("Errors: %0d result mismatches, %0d timeouts, %0d checker failures",
             mismatches, timeouts, dut0.chk0.fail_count);
    if (mismatches == 0 && timeouts == 0 && dut0.chk0.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/exec_alu_chk.sv ====
//----------------------------------------------------------------------
// Handshake and timing checker for the ALU execute unit, bound to
// every exec_alu instance. Failures raise $error and bump fail_count.
//----------------------------------------------------------------------

`timescale 1ns/1ns

module exec_alu_chk import exec_pkg::*; (
  input logic   clk,
  input logic   rst,
  input logic   d_val,
  input logic   d_rdy,
  input d_x_msg d_msg,
  input logic   w_val,
  input logic   w_rdy,
  input x_w_msg w_msg
);

  int fail_count = 0;

  logic       d_fire;
  logic       w_fire;

  // Messages accepted on D and not yet out on W
  logic [2:0] inflight;

  assign d_fire = d_val && d_rdy;
  assign w_fire = w_val && w_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      inflight <= 3'd0;
    end else if (d_fire && !w_fire) begin
      inflight <= inflight + 3'd1;
    end else if (w_fire && !d_fire) begin
      inflight <= inflight - 3'd1;
    end
  end

  //--------------------------------------------------------------------
  // W side protocol
  //--------------------------------------------------------------------

  // Stalled output holds
  w_hold: assert property (@(posedge clk) disable iff (rst)
    w_val && !w_rdy |=> w_val && $stable(w_msg))
    else begin $error("w_val or w_msg changed while stalled"); fail_count++; end

  // Nothing leaves that never came in
  w_origin: assert property (@(posedge clk) disable iff (rst)
    w_fire |-> inflight != 3'd0)
    else begin $error("W transfer without a D transfer"); fail_count++; end

  // Two stages at most
  depth: assert property (@(posedge clk) disable iff (rst)
    inflight <= 3'd2)
    else begin $error("more than two messages in flight"); fail_count++; end

  //--------------------------------------------------------------------
  // Reset and ready
  //--------------------------------------------------------------------

  reset_exit: assert property (@(posedge clk)
    $fell(rst) |-> !w_val && d_rdy)
    else begin $error("unit not empty after reset"); fail_count++; end

  // d_rdy low only with both stages full and W stalled
  d_stall: assert property (@(posedge clk) disable iff (rst)
    !d_rdy |-> w_val && !w_rdy)
    else begin $error("d_rdy low without W back-pressure"); fail_count++; end

  // Two cycles D to W when W was ready in between
  latency: assert property (@(posedge clk) disable iff (rst)
    $past(d_fire, 2) && $past(w_rdy) |->
      w_val && (w_msg.seq_num == $past(d_msg.seq_num, 2)))
    else begin $error("message late or out of order on W"); fail_count++; end

endmodule

bind exec_alu exec_alu_chk chk0 (.*);

// ==== verilog/exec_alu.sv ====
//----------------------------------------------------------------------
// ALU execute unit top level. Takes decoded micro-ops on the D side
// and returns writeback messages on the W side, both valid/ready.
// Two register stages around a combinational ALU, two cycles latency.
//----------------------------------------------------------------------

`timescale 1ns/1ns

module exec_alu import exec_pkg::*; (
  input  logic   clk,
  input  logic   rst,

  // From decode
  input  logic   d_val,
  output logic   d_rdy,
  input  d_x_msg d_msg,

  // To writeback
  output logic   w_val,
  input  logic   w_rdy,
  output x_w_msg w_msg
);

  //--------------------------------------------------------------------
  // Internal signals
  //--------------------------------------------------------------------

  // Handshake between the two stages
  logic        x_val;
  logic        x_rdy;

  // Micro-op held in the execute stage
  d_x_msg      x_msg;

  // ALU output
  logic [31:0] alu_result;

  // Writeback message built in execute
  x_w_msg      x_w;

  //--------------------------------------------------------------------
  // Input stage
  //--------------------------------------------------------------------

  pipe_reg #(
    .T (d_x_msg)
  ) x_in (
    .clk     (clk),
    .rst     (rst),
    .in_val  (d_val),
    .in_rdy  (d_rdy),
    .in_msg  (d_msg),
    .out_val (x_val),
    .out_rdy (x_rdy),
    .out_msg (x_msg)
  );

  //--------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------

  alu_datapath alu0 (
    .uop    (x_msg.uop),
    .op1    (x_msg.op1),
    .op2    (x_msg.op2),
    .result (alu_result)
  );

  //--------------------------------------------------------------------
  // Writeback message
  //--------------------------------------------------------------------

  // Tags and destination forwarded unchanged
  assign x_w.pc      = x_msg.pc;
  assign x_w.seq_num = x_msg.seq_num;
  assign x_w.waddr   = x_msg.waddr;
  assign x_w.wdata   = alu_result;

  // x0 is hardwired zero, suppress the write
  assign x_w.wen     = (x_msg.waddr != 5'd0);

  //--------------------------------------------------------------------
  // Output stage
  //--------------------------------------------------------------------

  pipe_reg #(
    .T (x_w_msg)
  ) x_out (
    .clk     (clk),
    .rst     (rst),
    .in_val  (x_val),
    .in_rdy  (x_rdy),
    .in_msg  (x_w),
    .out_val (w_val),
    .out_rdy (w_rdy),
    .out_msg (w_msg)
  );

endmodule

// ==== verilog/alu_datapath.sv ====
//----------------------------------------------------------------------
// Combinational RV32I integer ALU. Maps a micro-op and two 32-bit
// operands to a 32-bit result with zero cycles of latency.
// Add, sub and both compares share one adder.
//----------------------------------------------------------------------

`timescale 1ns/1ns

module alu_datapath import exec_pkg::*; (
  input  rv_uop       uop,
  input  logic [31:0] op1,
  input  logic [31:0] op2,
  output logic [31:0] result
);

  //--------------------------------------------------------------------
  // Shared adder
  //--------------------------------------------------------------------

  // Subtract mode for sub and the two compares
  logic        is_sub;

  // Second adder input, inverted when subtracting
  logic [31:0] addend;

  // 33-bit sum keeps the carry out
  logic [32:0] sum;

  // Compare results
  logic        lt_s;
  logic        lt_u;

  // Shift amount, low five bits of op2 only
  logic [4:0]  shamt;

  // Shifter outputs
  logic [31:0] sll_res;
  logic [31:0] srl_res;
  logic [31:0] sra_res;

  always_comb begin
    case (uop)
      UOP_SUB,
      UOP_SLT,
      UOP_SLTU: is_sub = 1'b1;
      default:  is_sub = 1'b0;
    endcase
  end

  assign addend = is_sub ? ~op2 : op2;

  // Two's complement: invert and carry in one
  assign sum = {1'b0, op1} + {1'b0, addend} + {32'd0, is_sub};

  //--------------------------------------------------------------------
  // Compares
  //--------------------------------------------------------------------

  // Unsigned: no carry out of a - b means a < b
  assign lt_u = !sum[32];

  // Signed: differing signs decide directly
  // otherwise the sign of the difference
  assign lt_s = (op1[31] != op2[31]) ? op1[31] : sum[31];

  //--------------------------------------------------------------------
  // Shifts
  //--------------------------------------------------------------------

  assign shamt   = op2[4:0];
  assign sll_res = op1 << shamt;
  assign srl_res = op1 >> shamt;
  // Arithmetic shift replicates the sign bit
  assign sra_res = $signed(op1) >>> shamt;

  //--------------------------------------------------------------------
  // Result select
  //--------------------------------------------------------------------

  always_comb begin
    case (uop)
      UOP_ADD:  result = sum[31:0];
      UOP_SUB:  result = sum[31:0];
      UOP_AND:  result = op1 & op2;
      UOP_OR:   result = op1 | op2;
      UOP_XOR:  result = op1 ^ op2;
      UOP_SLT:  result = {31'd0, lt_s};
      UOP_SLTU: result = {31'd0, lt_u};
      UOP_SLL:  result = sll_res;
      UOP_SRL:  result = srl_res;
      UOP_SRA:  result = sra_res;
      // Upper immediate comes pre-shifted from decode
      UOP_LUI:  result = op2;
      // Unused encodings give zero
      default:  result = 32'd0;
    endcase
  end

endmodule

// ==== verilog/pipe_reg.sv ====
//----------------------------------------------------------------------
// One-entry valid/ready pipeline stage with a type-parameterized
// payload. Full throughput: a new payload loads in the same edge the
// old one leaves. Used for both the D->X and X->W registers.
//----------------------------------------------------------------------

`timescale 1ns/1ns

module pipe_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,

  // Upstream side
  input  logic in_val,
  output logic in_rdy,
  input  T     in_msg,

  // Downstream side
  output logic out_val,
  input  logic out_rdy,
  output T     out_msg
);

  // Stage occupancy
  logic full;

  // Held payload
  T     data;

  // Load enable for the payload
  logic load;

  //--------------------------------------------------------------------
  // Handshake
  //--------------------------------------------------------------------

  // Room when empty or the held entry leaves this edge
  assign in_rdy = !full || out_rdy;
  assign load   = in_val && in_rdy;

  // Valid flag, cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_rdy) begin
      // Either refilled or drained
      full <= in_val;
    end
  end

  //--------------------------------------------------------------------
  // Payload
  //--------------------------------------------------------------------

  // Holds while stalled
  always_ff @(posedge clk) begin
    if (load) begin
      data <= in_msg;
    end
  end

  assign out_val = full;
  assign out_msg = data;

endmodule

// ==== verilog/exec_pkg.sv ====
//----------------------------------------------------------------------
// Shared types for the ALU execute unit: micro-op encoding, the
// sequence tag width and the two stage messages (D->X and X->W).
// Modules pull these in with a wildcard import in their header.
//----------------------------------------------------------------------

package exec_pkg;

  //--------------------------------------------------------------------
  // Widths
  //--------------------------------------------------------------------

  // In-flight sequence tag width, shared by both messages
  localparam int SEQ_NUM_BITS = 5;

  //--------------------------------------------------------------------
  // ALU micro-ops
  //--------------------------------------------------------------------

  // RV32I integer ops handled by this unit
  // Register and immediate forms map to the same uop
  typedef enum logic [3:0] {
    UOP_ADD  = 4'd0,
    UOP_SUB  = 4'd1,
    UOP_AND  = 4'd2,
    UOP_OR   = 4'd3,
    UOP_XOR  = 4'd4,
    UOP_SLT  = 4'd5,
    UOP_SLTU = 4'd6,
    UOP_SLL  = 4'd7,
    UOP_SRL  = 4'd8,
    UOP_SRA  = 4'd9,
    // Upper immediate arrives already shifted in op2
    UOP_LUI  = 4'd10
  } rv_uop;

  //--------------------------------------------------------------------
  // Decode to execute payload
  //--------------------------------------------------------------------

  // 110 bits total
  typedef struct packed {
    // Instruction address, carried through
    logic [31:0]             pc;
    // Program order tag
    logic [SEQ_NUM_BITS-1:0] seq_num;
    // Source operands, already read or immediate
    logic [31:0]             op1;
    logic [31:0]             op2;
    // Destination register index
    logic [4:0]              waddr;
    rv_uop                   uop;
  } d_x_msg;

  //--------------------------------------------------------------------
  // Execute to writeback payload
  //--------------------------------------------------------------------

  // 75 bits total
  typedef struct packed {
    logic [31:0]             pc;
    logic [SEQ_NUM_BITS-1:0] seq_num;
    logic [4:0]              waddr;
    // ALU result
    logic [31:0]             wdata;
    // Low for writes to x0
    logic                    wen;
  } x_w_msg;

endpackage
